// ==== rv_pkg.sv ====
/*
 * Shared types and constants for the RV32I multi-cycle core.
 * Every core file refers to these by scoped name.
 */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;    // register or memory word
    typedef logic [31:0]     addr_t;    // byte address
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      strb_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [4:0]      opcode_t;  // ins[6:2]

    // ========================================================================
    // major opcodes
    // ========================================================================
    localparam opcode_t op_load   = 5'b00000;
    localparam opcode_t op_op_imm = 5'b00100;
    localparam opcode_t op_auipc  = 5'b00101;
    localparam opcode_t op_store  = 5'b01000;
    localparam opcode_t op_op     = 5'b01100;
    localparam opcode_t op_lui    = 5'b01101;
    localparam opcode_t op_branch = 5'b11000;
    localparam opcode_t op_jalr   = 5'b11001;
    localparam opcode_t op_jal    = 5'b11011;

    // load and store sizes
    localparam funct3_t f3_byte   = 3'b000;
    localparam funct3_t f3_half   = 3'b001;
    localparam funct3_t f3_word   = 3'b010;
    localparam funct3_t f3_byte_u = 3'b100;
    localparam funct3_t f3_half_u = 3'b101;

    typedef enum logic [2:0] {
        s_init,                         // register clear running
        s_fetch,
        s_exec,
        s_mem,
        s_halt                          // after a trap
    } core_state_e;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  funct3;
        logic     alt;                  // funct7 bit 5
        word_t    imm;                  // sign-extended, type by opcode
        logic     legal;
    } dec_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;                    // word aligned
        word_t wdata;
        strb_t wstrb;                   // zero for a read
    } dmem_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } dmem_rsp_t;

endpackage

`default_nettype wire

// ==== rv_decode.sv ====
/*
 * Combinational instruction decoder. Splits the fields, builds the
 * immediate chosen by the opcode and flags unsupported encodings.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t ins,
    output rv_pkg::dec_t       dec
);

    rv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::funct3_t f3;
    logic [6:0]      funct7;
    logic            legal_op;

    assign f3     = ins[14:12];
    assign funct7 = ins[31:25];

    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        dec.opcode = ins[6:2];
        dec.rd     = ins[11:7];
        dec.rs1    = ins[19:15];
        dec.rs2    = ins[24:20];
        dec.funct3 = f3;
        dec.alt    = ins[30];

        case (dec.opcode)
            rv_pkg::op_store:              dec.imm = imm_s;
            rv_pkg::op_branch:             dec.imm = imm_b;
            rv_pkg::op_lui, rv_pkg::op_auipc: dec.imm = imm_u;
            rv_pkg::op_jal:                dec.imm = imm_j;
            default:                       dec.imm = imm_i;
        endcase

        case (dec.opcode)
            rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal: legal_op = 1'b1;
            rv_pkg::op_jalr:   legal_op = f3 == 3'b000;
            rv_pkg::op_branch: legal_op = f3[2:1] != 2'b01;
            rv_pkg::op_load:   legal_op = f3 inside {rv_pkg::f3_byte, rv_pkg::f3_half,
                                   rv_pkg::f3_word, rv_pkg::f3_byte_u, rv_pkg::f3_half_u};
            rv_pkg::op_store:  legal_op = f3 inside {rv_pkg::f3_byte, rv_pkg::f3_half,
                                   rv_pkg::f3_word};
            rv_pkg::op_op:     legal_op = funct7 == 7'b0000000 ||
                                   (funct7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            rv_pkg::op_op_imm: begin
                case (f3)
                    3'b001:  legal_op = funct7 == 7'b0000000;    // slli
                    3'b101:  legal_op = funct7 inside {7'b0000000, 7'b0100000, 7'b0110000};
                    default: legal_op = 1'b1;
                endcase
            end
            default: legal_op = 1'b0;
        endcase

        dec.legal = legal_op && ins[1:0] == 2'b11;   // no compressed forms
    end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
/*
 * 32 x 32 register file with two combinational read ports and one
 * write port. After reset it clears itself, x2 gets the stack pointer.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
    parameter rv_pkg::word_t RESET_SP = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     m_rst,
    output logic                    init_done,
    input  wire rv_pkg::reg_idx_t   rs1,
    input  wire rv_pkg::reg_idx_t   rs2,
    output rv_pkg::word_t           rs1_data,
    output rv_pkg::word_t           rs2_data,
    input  wire                     we,
    input  wire rv_pkg::reg_idx_t   wr_idx,
    input  wire rv_pkg::word_t      wr_data
);

    rv_pkg::word_t    regs [32];
    rv_pkg::reg_idx_t clr_cnt;              // next register to clear

    assign init_done = clr_cnt == '0;

    always_ff @(posedge clk) begin
        if (m_rst) begin
            clr_cnt <= 5'd31;
        end else if (!init_done) begin
            clr_cnt <= clr_cnt - 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!init_done) begin
            regs[clr_cnt] <= (clr_cnt == 5'd2) ? RESET_SP : '0;
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];   // old value on write cycle
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
/*
 * Combinational execute unit. Computes OP and OP-IMM results, upper
 * immediates, link values, branch decisions and jump targets.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire rv_pkg::dec_t   dec,
    input  wire rv_pkg::addr_t  pc,
    input  wire rv_pkg::word_t  rs1_data,
    input  wire rv_pkg::word_t  rs2_data,
    output rv_pkg::word_t       result,
    output logic                take_branch,
    output rv_pkg::addr_t       target
);

    rv_pkg::word_t a, b, sum, pc_imm, op_res;
    logic [63:0]   rot;
    logic [4:0]    shamt;
    logic          is_op, lt_s, lt_u, cond;

    assign is_op  = dec.opcode == rv_pkg::op_op;
    assign a      = rs1_data;
    assign b      = (is_op || dec.opcode == rv_pkg::op_branch) ? rs2_data : dec.imm;
    assign sum    = a + b;                  // also load/store and jalr address
    assign pc_imm = pc + dec.imm;
    assign lt_u   = a < b;
    assign lt_s   = $signed(a) < $signed(b);
    assign shamt  = b[4:0];
    assign rot    = {a, a} >> shamt;

    always_comb begin
        case (dec.funct3)
            3'b000:  op_res = (is_op && dec.alt) ? a - b : sum;
            3'b001:  op_res = a << shamt;
            3'b010:  op_res = {31'b0, lt_s};
            3'b011:  op_res = {31'b0, lt_u};
            3'b100:  op_res = a ^ b;
            3'b101: begin
                if (!is_op && dec.imm[9]) op_res = rot[31:0];        // rori
                else if (dec.alt)         op_res = $signed(a) >>> shamt;
                else                      op_res = a >> shamt;
            end
            3'b110:  op_res = a | b;
            default: op_res = a & b;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            rv_pkg::op_lui:                  result = dec.imm;
            rv_pkg::op_auipc:                result = pc_imm;
            rv_pkg::op_jal, rv_pkg::op_jalr: result = pc + 32'd4;   // link
            rv_pkg::op_op, rv_pkg::op_op_imm: result = op_res;
            default:                         result = sum;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  cond = a == b;
            3'b001:  cond = a != b;
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    // jumps always redirect the pc
    assign take_branch = (dec.opcode == rv_pkg::op_branch && cond) ||
                         dec.opcode == rv_pkg::op_jal || dec.opcode == rv_pkg::op_jalr;
    assign target = (dec.opcode == rv_pkg::op_jalr) ? {sum[31:1], 1'b0} : pc_imm;

endmodule

`default_nettype wire

// ==== rv_lsu.sv ====
/*
 * Load/store unit. Issues one word-aligned request on the data port,
 * holds it until ready, places store lanes and aligns load data.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
    input  wire                     clk,
    input  wire                     m_rst,
    input  wire                     start,
    input  wire rv_pkg::addr_t      addr,
    input  wire                     is_store,
    input  wire rv_pkg::funct3_t    funct3,
    input  wire rv_pkg::word_t      store_data,
    output rv_pkg::dmem_req_t       dmem_req,
    input  wire rv_pkg::dmem_rsp_t  dmem_rsp,
    output logic                    mem_done,
    output rv_pkg::word_t           load_data
);

    rv_pkg::dmem_req_t req_q;
    logic [1:0]        lane_q;              // byte offset of the access
    rv_pkg::funct3_t   f3_q;
    rv_pkg::word_t     wdata, shifted;
    rv_pkg::strb_t     strb;

    // ========================================================================
    // store lanes
    // ========================================================================
    always_comb begin
        case (funct3)
            rv_pkg::f3_byte: begin
                wdata = {4{store_data[7:0]}};
                strb  = 4'b0001 << addr[1:0];
            end
            rv_pkg::f3_half: begin
                wdata = {2{store_data[15:0]}};
                strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = store_data;
                strb  = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q.addr  <= {addr[31:2], 2'b00};
            req_q.wdata <= wdata;
            req_q.wstrb <= is_store ? strb : '0;   // zero strobe is a read
            lane_q      <= addr[1:0];
            f3_q        <= funct3;
        end
        if (m_rst) begin
            req_q.valid <= 1'b0;
        end else if (start) begin
            req_q.valid <= 1'b1;
        end else if (dmem_rsp.ready) begin
            req_q.valid <= 1'b0;                    // drops after the ready cycle
        end
    end

    assign dmem_req = req_q;
    assign mem_done = req_q.valid && dmem_rsp.ready;

    // ========================================================================
    // load alignment and extension
    // ========================================================================
    assign shifted = dmem_rsp.rdata >> {lane_q, 3'b000};

    always_comb begin
        case (f3_q)
            rv_pkg::f3_byte:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            rv_pkg::f3_half:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            rv_pkg::f3_byte_u: load_data = {24'b0, shifted[7:0]};
            rv_pkg::f3_half_u: load_data = {16'b0, shifted[15:0]};
            default:           load_data = shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_control.sv ====
/*
 * Sequencer of the core. Steps each instruction through fetch, execute
 * and an optional memory phase, keeps the pc and the sticky trap.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_control #(
    parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  wire                    clk,
    input  wire                    m_rst,
    input  wire                    init_done,
    output rv_pkg::imem_req_t      imem_req,
    input  wire                    imem_ready,
    input  wire rv_pkg::word_t     imem_rdata,
    output rv_pkg::word_t          ins,
    input  wire rv_pkg::dec_t      dec,
    input  wire rv_pkg::word_t     alu_result,
    input  wire                    take_branch,
    input  wire rv_pkg::addr_t     target,
    output rv_pkg::addr_t          pc,
    output logic                   mem_start,
    input  wire                    mem_done,
    input  wire rv_pkg::word_t     load_data,
    output logic                   rd_we,
    output rv_pkg::reg_idx_t       rd_idx,
    output rv_pkg::word_t          rd_data,
    output logic                   trap
);

    rv_pkg::core_state_e state;
    logic                is_load, is_mem, writes_rd;

    assign is_load   = dec.opcode == rv_pkg::op_load;
    assign is_mem    = is_load || dec.opcode == rv_pkg::op_store;
    assign writes_rd = !is_mem && dec.opcode != rv_pkg::op_branch; // loads write in s_mem

    assign imem_req.valid = state == rv_pkg::s_fetch;
    assign imem_req.addr  = pc;

    assign mem_start = state == rv_pkg::s_exec && dec.legal && is_mem;

    // ========================================================================
    // register write port
    // ========================================================================
    assign rd_idx  = dec.rd;
    assign rd_data = (state == rv_pkg::s_mem) ? load_data : alu_result;

    always_comb begin
        rd_we = 1'b0;
        if (dec.rd != '0) begin                 // x0 stays zero
            if (state == rv_pkg::s_exec) begin
                rd_we = dec.legal && writes_rd;
            end else if (state == rv_pkg::s_mem) begin
                rd_we = mem_done && is_load;
            end
        end
    end

    // ========================================================================
    // sequencing
    // ========================================================================
    always_ff @(posedge clk) begin
        if (m_rst) begin
            state <= rv_pkg::s_init;
            pc    <= RESET_PC;
            trap  <= 1'b0;
        end else begin
            case (state)
                rv_pkg::s_init: begin
                    if (init_done) state <= rv_pkg::s_fetch;
                end
                rv_pkg::s_fetch: begin
                    if (imem_ready) state <= rv_pkg::s_exec;   // word latched below
                end
                rv_pkg::s_exec: begin
                    if (!dec.legal) begin
                        trap  <= 1'b1;                  // sticky until m_rst
                        state <= rv_pkg::s_halt;
                    end else begin
                        pc    <= take_branch ? target : pc + 32'd4;
                        state <= is_mem ? rv_pkg::s_mem : rv_pkg::s_fetch;
                    end
                end
                rv_pkg::s_mem: begin
                    if (mem_done) state <= rv_pkg::s_fetch;
                end
                default: state <= rv_pkg::s_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_pkg::s_fetch && imem_ready) ins <= imem_rdata;
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
/*
 * RV32I core top level. Connects sequencer, decoder, register file,
 * ALU and load/store unit to the program and data ports.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::addr_t RESET_PC = 32'h0000_0000,
    parameter rv_pkg::word_t RESET_SP = 32'h0000_0000
) (
    input  wire                      clk,
    input  wire                      m_rst,
    output logic                     trap,
    output rv_pkg::imem_req_t        imem_req,
    input  wire                      imem_ready,
    input  wire rv_pkg::word_t       imem_rdata,
    output rv_pkg::dmem_req_t        dmem_req,
    input  wire rv_pkg::dmem_rsp_t   dmem_rsp
);

    rv_pkg::word_t    ins;
    rv_pkg::dec_t     dec;
    rv_pkg::word_t    rs1_data, rs2_data;
    rv_pkg::word_t    alu_result, load_data, rd_data;
    rv_pkg::addr_t    pc, target;
    rv_pkg::reg_idx_t rd_idx;
    logic             init_done, take_branch, mem_start, mem_done, rd_we;
    logic             is_store;

    assign is_store = dec.opcode == rv_pkg::op_store;

    rv_control #(.RESET_PC(RESET_PC)) u_control (
        .clk, .m_rst, .init_done, .imem_req, .imem_ready, .imem_rdata,
        .ins, .dec, .alu_result, .take_branch, .target, .pc,
        .mem_start, .mem_done, .load_data, .rd_we, .rd_idx, .rd_data, .trap
    );

    rv_decode u_decode (.ins, .dec);

    rv_regfile #(.RESET_SP(RESET_SP)) u_regfile (
        .clk, .m_rst, .init_done,
        .rs1(dec.rs1), .rs2(dec.rs2), .rs1_data, .rs2_data,
        .we(rd_we), .wr_idx(rd_idx), .wr_data(rd_data)
    );

    rv_alu u_alu (
        .dec, .pc, .rs1_data, .rs2_data,
        .result(alu_result), .take_branch, .target
    );

    rv_lsu u_lsu (
        .clk, .m_rst, .start(mem_start), .addr(alu_result), .is_store,
        .funct3(dec.funct3), .store_data(rs2_data), .dmem_req, .dmem_rsp,
        .mem_done, .load_data
    );

endmodule

`default_nettype wire

// ==== rv_core_properties.sv ====
/*
 * Handshake and trap assertions for the core ports.
 * Attached to every rv_core instance through bind.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
    input wire                    clk,
    input wire                    m_rst,
    input wire                    trap,
    input wire rv_pkg::imem_req_t imem_req,
    input wire                    imem_ready,
    input wire rv_pkg::dmem_req_t dmem_req,
    input wire rv_pkg::dmem_rsp_t dmem_rsp
);

    int unsigned fail_cnt = 0;              // read by the testbench at the end

    a_imem_stable: assert property (@(posedge clk) disable iff (m_rst)
        imem_req.valid && !imem_ready |=> $stable(imem_req))
        else begin $error("imem request changed while stalled"); fail_cnt++; end

    a_dmem_stable: assert property (@(posedge clk) disable iff (m_rst)
        dmem_req.valid && !dmem_rsp.ready |=> $stable(dmem_req))
        else begin $error("dmem request changed while stalled"); fail_cnt++; end

    a_trap_sticky: assert property (@(posedge clk) trap && !m_rst |=> trap)
        else begin $error("trap fell without reset"); fail_cnt++; end

    a_halt_quiet: assert property (@(posedge clk) disable iff (m_rst)
        trap |-> !imem_req.valid && !dmem_req.valid)
        else begin $error("request raised while trapped"); fail_cnt++; end

endmodule

bind rv_core rv_core_properties u_props (.*);

`default_nettype wire

// ==== tb_rv_core.sv ====
/*
 * Testbench for rv_core. Builds small programs, runs them against
 * randomly stalling memory models and checks every store on the data port.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam rv_pkg::word_t RESET_SP = 32'h0000_0f00;
    localparam int period = 4;
    localparam int n_tests = 6;
    localparam int stall_budget = 24;       // cycles allowed per instruction
    localparam int timeout_ns = n_tests * (256 * stall_budget + 64) * period;

    typedef struct packed {
        rv_pkg::addr_t addr;
        rv_pkg::word_t data;                // already masked by strb
        rv_pkg::strb_t strb;
    } store_t;

    logic clk, m_rst, trap, imem_ready, d_ready;
    rv_pkg::imem_req_t imem_req;
    rv_pkg::dmem_req_t dmem_req;
    rv_pkg::dmem_rsp_t dmem_rsp;
    rv_pkg::word_t prog [256];
    rv_pkg::word_t dmem [256];
    store_t exp_q [$];
    store_t seen;
    rv_pkg::word_t m, rdy_s = 32'd35, op_s = 32'd35;
    logic b;
    int pc_w, out_k, errors = 0, checks = 0, tests = 0;

    rv_core #(.RESET_PC(32'h0), .RESET_SP(RESET_SP)) u_dut (
        .clk, .m_rst, .trap, .imem_req, .imem_ready,
        .imem_rdata(imem_req.valid ? prog[imem_req.addr[9:2]] : 32'h0),   // zero is illegal
        .dmem_req, .dmem_rsp
    );

    assign dmem_rsp = {d_ready, dmem[dmem_req.addr[9:2]]};

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic rv_pkg::word_t lfsr_step(rv_pkg::word_t s);
        return s[0] ? (s >> 1) ^ 32'ha300_0000 : s >> 1;   // galois form
    endfunction

    function automatic rv_pkg::word_t rand_word();
        rv_pkg::word_t w;
        for (int i = 0; i < 32; i++) begin
            op_s = lfsr_step(op_s);
            w[i] = op_s[0];
        end
        return w;
    endfunction

    always @(posedge clk) begin             // ready high three times in four
        rdy_s = lfsr_step(rdy_s);
        b = rdy_s[0];
        rdy_s = lfsr_step(rdy_s);
        imem_ready <= b | rdy_s[0];
        rdy_s = lfsr_step(rdy_s);
        b = rdy_s[0];
        rdy_s = lfsr_step(rdy_s);
        d_ready <= b | rdy_s[0];
    end

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic rv_pkg::word_t fill_word(rv_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h8080_8080;
    endfunction

    function automatic rv_pkg::word_t strb_mask(rv_pkg::strb_t s);
        rv_pkg::word_t r;
        for (int i = 0; i < 4; i++) r[8*i +: 8] = {8{s[i]}};
        return r;
    endfunction

    // op: 0 add 1 sub 2 sll 3 slt 4 sltu 5 xor 6 srl 7 sra 8 or 9 and 10 ror
    function automatic rv_pkg::word_t ref_alu(int op, rv_pkg::word_t a, rv_pkg::word_t b);
        logic [5:0] s;
        s = {1'b0, b[4:0]};
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a << s;
            3: return {31'b0, $signed(a) < $signed(b)};
            4: return {31'b0, a < b};
            5: return a ^ b;
            6: return a >> s;
            7: return $signed(a) >>> s;
            8: return a | b;
            9: return a & b;
            default: return (a >> s) | (a << (6'd32 - s));
        endcase
    endfunction

    function automatic logic ref_branch(int f3, rv_pkg::word_t a, rv_pkg::word_t b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rv_pkg::word_t ref_load(int f3, rv_pkg::word_t w, int o);
        rv_pkg::word_t sh;
        sh = w >> (8 * o);
        case (f3)
            0: return {{24{sh[7]}}, sh[7:0]};
            1: return {{16{sh[15]}}, sh[15:0]};
            4: return {24'b0, sh[7:0]};
            5: return {16'b0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    // ========================================================================
    // program builder
    // ========================================================================
    function automatic rv_pkg::word_t enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                            rv_pkg::opcode_t opc);
        return {imm, 5'(rs1), 3'(f3), 5'(rd), opc, 2'b11};
    endfunction

    function automatic rv_pkg::word_t enc_s(logic [11:0] imm, int rs2, int f3);
        return {imm[11:5], 5'(rs2), 5'd0, 3'(f3), imm[4:0], rv_pkg::op_store, 2'b11};
    endfunction

    function automatic rv_pkg::word_t enc_b(logic [12:0] imm, int f3);   // x1 vs x2
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'(f3), imm[4:1], imm[11],
                rv_pkg::op_branch, 2'b11};
    endfunction

    function automatic rv_pkg::word_t enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rv_pkg::op_jal, 2'b11};
    endfunction

    task automatic emit(rv_pkg::word_t w);
        prog[pc_w] = w;
        pc_w++;
    endtask

    task automatic load_const(int rd, rv_pkg::word_t v);
        rv_pkg::word_t hi;
        hi = (v + 32'h800) >> 12;
        emit({hi[19:0], 5'(rd), rv_pkg::op_lui, 2'b11});
        emit(enc_i(v[11:0], rd, 0, rd, rv_pkg::op_op_imm));
    endtask

    task automatic store_out(int rs, rv_pkg::word_t v);
        emit(enc_s(12'(out_k * 4), rs, 2));
        exp_q.push_back('{32'(out_k * 4), v, 4'hf});
        out_k++;
    endtask

    // ========================================================================
    // checks and store monitor
    // ========================================================================
    task automatic check(string name, rv_pkg::word_t got, rv_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!m_rst && dmem_req.valid && d_ready && dmem_req.wstrb != '0) begin
            m = strb_mask(dmem_req.wstrb);
            dmem[dmem_req.addr[9:2]] <= (dmem[dmem_req.addr[9:2]] & ~m) | (dmem_req.wdata & m);
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected store to address %h", dmem_req.addr);
            end else begin
                seen = exp_q.pop_front();
                check("dmem_req.addr", dmem_req.addr, seen.addr);
                check("dmem_req.wdata", dmem_req.wdata & m, seen.data);
                check("dmem_req.wstrb", 32'(dmem_req.wstrb), 32'(seen.strb));
            end
        end
    end

    task automatic start_test();
        @(posedge clk);
        m_rst <= 1'b1;
        pc_w = 0;
        out_k = 0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = enc_j(21'd0, 0);       // self loop ends every program
            dmem[i] = fill_word(32'(i * 4));
        end
    endtask

    task automatic finish_test(string name, bit expect_trap);
        int err0;
        err0 = errors;
        repeat (4) @(posedge clk);
        m_rst <= 1'b0;
        if (expect_trap) begin
            wait (trap === 1'b1);
            repeat (20) @(posedge clk);
            check("imem_req.valid", 32'(imem_req.valid), 32'd0);
            check("dmem_req.valid", 32'(dmem_req.valid), 32'd0);
            check("pending stores", 32'(exp_q.size()), 32'd0);
        end else begin
            while (exp_q.size() != 0) @(posedge clk);
            repeat (8) @(posedge clk);
            check("trap", 32'(trap), 32'd0);
        end
        tests++;
        $display("test %-6s %s (%0d errors)", name, errors == err0 ? "ok" : "failed",
                 errors - err0);
    endtask

    initial begin                            // watchdog
        #(timeout_ns);
        $display("timeout: the tests did not finish in %0d ns", timeout_ns);
        $display("** FAIL **");
        $finish;
    end

    // ========================================================================
    // tests
    // ========================================================================
    initial begin
        rv_pkg::word_t a, v, exp_mem;
        int pa [3] = '{5, -1, 1};
        int pb [3] = '{5, 1, -1};
        int r_f3 [11] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7, 5};
        int br_f3 [6] = '{0, 1, 4, 5, 6, 7};    // beq bne blt bge bltu bgeu
        int sizes [5] = '{0, 1, 2, 4, 5};
        int step, q;
        m_rst = 1'b1;
        imem_ready = 1'b0;
        d_ready = 1'b0;

        start_test();                        // reset values of the registers
        store_out(1, 32'd0);
        store_out(2, RESET_SP);
        store_out(3, 32'd0);
        finish_test("reset", 1'b0);

        start_test();
        for (int p = 0; p < 3; p++) begin
            a = rand_word();
            v = rand_word();
            load_const(1, a);
            load_const(2, v);
            for (int op = 0; op < 10; op++) begin
                emit({(op == 1 || op == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(r_f3[op]), 5'd3,
                      rv_pkg::op_op, 2'b11});
                store_out(3, ref_alu(op, a, v));
            end
            for (int op = 0; op < 11; op++) begin
                if (op == 1) continue;       // no subi
                if (op inside {2, 6, 7, 10}) begin
                    emit(enc_i({op == 7 ? 7'h20 : op == 10 ? 7'h30 : 7'h00, v[4:0]}, 1,
                               r_f3[op], 3, rv_pkg::op_op_imm));
                    store_out(3, ref_alu(op, a, {27'b0, v[4:0]}));
                end else begin
                    emit(enc_i(v[11:0], 1, r_f3[op], 3, rv_pkg::op_op_imm));
                    store_out(3, ref_alu(op, a, {{20{v[11]}}, v[11:0]}));
                end
            end
        end
        finish_test("alu", 1'b0);

        start_test();
        for (int p = 0; p < 3; p++) begin
            emit(enc_i(12'(pa[p]), 0, 0, 1, rv_pkg::op_op_imm));
            emit(enc_i(12'(pb[p]), 0, 0, 2, rv_pkg::op_op_imm));
            foreach (br_f3[j]) begin
                emit(enc_b(13'd12, br_f3[j]));
                emit(enc_i(12'd1, 0, 0, 5, rv_pkg::op_op_imm));  // not taken marker
                emit(enc_j(21'd8, 0));
                emit(enc_i(12'd2, 0, 0, 5, rv_pkg::op_op_imm));  // taken marker
                store_out(5, ref_branch(br_f3[j], 32'(pa[p]), 32'(pb[p])) ? 32'd2 : 32'd1);
            end
        end
        q = pc_w * 4;
        emit(enc_j(21'd8, 6));
        emit(enc_s(12'h2f0, 0, 2));          // skipped
        store_out(6, 32'(q + 4));
        q = pc_w * 4 + 4;                    // address of the jalr
        emit(enc_i(12'(q + 9), 0, 0, 7, rv_pkg::op_op_imm));
        emit(enc_i(12'd0, 7, 0, 8, rv_pkg::op_jalr));
        emit(enc_s(12'h2f4, 0, 2));          // skipped
        store_out(8, 32'(q + 4));
        finish_test("flow", 1'b0);

        start_test();
        for (int w = 32'h300; w <= 32'h304; w += 4) begin
            foreach (sizes[s]) begin
                step = sizes[s] == 2 ? 4 : (sizes[s] % 4 == 1 ? 2 : 1);
                for (int o = 0; o < 4; o += step) begin
                    emit(enc_i(12'(w + o), 0, sizes[s], 3, rv_pkg::op_load));
                    store_out(3, ref_load(sizes[s], fill_word(32'(w)), o));
                end
            end
        end
        finish_test("load", 1'b0);

        start_test();
        v = rand_word();
        load_const(1, v);
        for (int h = 0; h < 2; h++) begin
            exp_mem = fill_word(32'(32'h380 + 4 * h));
            for (int o = 0; o < 4; o += h + 1) begin
                m = strb_mask(4'(h ? 4'b0011 << o : 4'b0001 << o));
                a = h ? {2{v[15:0]}} : {4{v[7:0]}};   // replicated lanes
                emit(enc_s(12'(32'h380 + 4 * h + o), 1, h));
                exp_q.push_back('{32'(32'h380 + 4 * h), a & m,
                                  4'(h ? 4'b0011 << o : 4'b0001 << o)});
                exp_mem = (exp_mem & ~m) | (a & m);
                emit(enc_i(12'(32'h380 + 4 * h), 0, 2, 3, rv_pkg::op_load));
                store_out(3, exp_mem);
            end
        end
        finish_test("store", 1'b0);

        start_test();
        emit(enc_i(12'd5, 0, 0, 1, rv_pkg::op_op_imm));
        store_out(1, 32'd5);
        emit(32'h0000_0000);                 // illegal word
        emit(enc_s(12'h004, 1, 2));
        emit(enc_s(12'h008, 1, 2));
        finish_test("trap", 1'b1);

        errors += u_dut.u_props.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f tb.f --Mdir obj_dir -o sim_rv_core
./obj_dir/sim_rv_core | tee sim.log

if grep -qxF '** PASS **' sim.log; then
    exit 0
fi
exit 1
